// ==== build.f ====
+incdir+.
dcache_pkg.sv
dcache_io_route.sv
dcache_array.sv
dcache_ctrl.sv
dcache_top.sv
dcache_chk.sv
tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_dcache -f build.f -o sim_dcache; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
if [ "$run_status" -ne 0 ]; then
	echo "simulator returned status $run_status"
	exit 1
fi
exit 0

// ==== tb_dcache.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache;

	localparam logic [31:0] MEM_KEY = 32'h5A3C_96E1;
	localparam logic [31:0] IO_KEY = 32'hC0DE_0000;
	localparam logic [31:0] IO_BASE = 32'h8000_0000;
	localparam int TMO = 200;

	logic                  iCLOCK;
	logic                  inRESET;
	logic                  remove;
	logic                  sysinfo_iosr_valid;
	logic [31:0]           sysinfo_iosr;
	logic                  ldst_req;
	dcache_pkg::ldst_req_t ldst;
	logic                  ldst_busy;
	logic                  ldst_valid;
	logic [31:0]           ldst_rdata;
	logic                  mem_req;
	dcache_pkg::mem_req_t  mem;
	logic                  mem_lock;
	logic                  mem_valid;
	logic [63:0]           mem_rdata;
	logic                  io_req;
	dcache_pkg::io_req_t   io;
	logic                  io_busy;
	logic                  io_valid;
	logic [31:0]           io_rdata;

	int cyc;
	int tests;
	int checks;
	int errors;
	int test_err;

	// Memory model state
	logic [31:0] store [logic [31:0]];
	logic        resp_rw_q [$];
	logic [31:0] resp_addr_q [$];
	int          resp_due_q [$];
	int          lock_left;
	int          rd_issued;
	int          wr_issued;
	logic [7:0]  beat_seen;

	// IO model state
	logic        io_pend;
	logic        io_last_rw;
	logic [1:0]  io_last_size;
	logic [31:0] io_last_addr;
	logic [31:0] io_last_wdata;
	int          io_seen;

	dcache_top dut0 (.*);

	initial iCLOCK = 1'b0;
	always #4 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK) begin
		cyc <= cyc + 1;
	end

	// Unwritten words read back as address XOR key
	function automatic logic [31:0] model_word(input logic [31:0] a);
		logic [31:0] w;
		w = {a[31:2], 2'b00};
		if (store.exists(w)) begin
			return store[w];
		end
		return w ^ MEM_KEY;
	endfunction

	task automatic model_write(input dcache_pkg::mem_req_t r);
		logic [31:0] w;
		logic [31:0] old;
		w = {r.addr[31:2], 2'b00};
		old = model_word(w);
		case (r.size)
			dcache_pkg::SIZE_BYTE: old[r.addr[1:0]*8 +: 8] = r.wdata[7:0];
			dcache_pkg::SIZE_HALF: old[r.addr[1]*16 +: 16] = r.wdata[15:0];
			default: old = r.wdata;
		endcase
		store[w] = old;
	endtask

	always @(negedge iCLOCK) begin : mem_model
		logic [31:0] a;
		logic        rw;
		if (!inRESET) begin
			mem_lock = 1'b0;
			mem_valid = 1'b0;
			mem_rdata = '0;
			lock_left = 0;
		end else begin
			mem_valid = 1'b0;
			if (resp_due_q.size() > 0 && resp_due_q[0] <= cyc) begin
				void'(resp_due_q.pop_front());
				rw = resp_rw_q.pop_front();
				a = resp_addr_q.pop_front();
				mem_valid = 1'b1;
				mem_rdata = rw ? {model_word(a + 32'd4), model_word(a)} : 64'd0;
			end
			// Lock runs of one or two cycles
			if (lock_left > 0) begin
				mem_lock = 1'b1;
				lock_left--;
			end else begin
				mem_lock = 1'b0;
				if ($urandom_range(3, 0) == 0) begin
					lock_left = int'($urandom_range(2, 1));
				end
			end
			if (mem_req && !mem_lock) begin
				resp_rw_q.push_back(mem.rw);
				resp_addr_q.push_back(mem.addr);
				resp_due_q.push_back(cyc + 1 + int'($urandom_range(2, 0)));
				if (mem.rw) begin
					rd_issued++;
					beat_seen[mem.addr[5:3]] = 1'b1;
				end else begin
					wr_issued++;
					model_write(mem);
				end
			end
		end
	end

	// IO answers in the cycle after it takes a request
	always @(negedge iCLOCK) begin
		io_valid = 1'b0;
		if (io_pend) begin
			io_valid = 1'b1;
			io_rdata = io_last_addr ^ IO_KEY;
			io_pend = 1'b0;
		end
		#2;
		if (inRESET && io_req && !ldst_busy) begin
			io_pend = 1'b1;
			io_last_rw = io.rw;
			io_last_size = io.size;
			io_last_addr = io.addr;
			io_last_wdata = io.wdata;
			io_seen++;
		end
	end

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_err++;
			$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %-8s %0s", name, (test_err == 0) ? "ok" : "with errors");
		test_err = 0;
	endtask

	task automatic access(input logic rw, input dcache_pkg::access_size_e size,
			input logic [31:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output int lat);
		int t;
		int acc;
		@(negedge iCLOCK);
		ldst_req = 1'b1;
		ldst.rw = rw;
		ldst.size = size;
		ldst.addr = addr;
		ldst.wdata = wdata;
		t = 0;
		#1;
		while (ldst_busy && t < TMO) begin
			t++;
			@(negedge iCLOCK);
			#1;
		end
		if (t >= TMO) begin
			errors++;
			test_err++;
			$display("Timeout: access to %h was never accepted", addr);
		end
		acc = cyc;
		@(negedge iCLOCK);
		ldst_req = 1'b0;
		t = 0;
		#1;
		while (!ldst_valid && t < TMO) begin
			t++;
			@(negedge iCLOCK);
			#1;
		end
		if (t >= TMO) begin
			errors++;
			test_err++;
			$display("Timeout: no answer for access to %h", addr);
		end
		rdata = ldst_rdata;
		lat = cyc - acc;
	endtask

	// Hit means one cycle latency and no refill
	task automatic read_expect(input logic [31:0] addr, input logic want_hit);
		logic [31:0] d;
		int lat;
		int rd0;
		rd0 = rd_issued;
		access(1'b1, dcache_pkg::SIZE_WORD, addr, '0, d, lat);
		check_eq("read data", d, model_word(addr));
		if (want_hit) begin
			check_eq("hit latency", 32'(lat), 32'd1);
			check_eq("hit mem reads", 32'(rd_issued - rd0), 32'd0);
		end else begin
			check_eq("miss mem reads", 32'(rd_issued - rd0), 32'd8);
		end
	endtask

	task automatic write_word(input dcache_pkg::access_size_e size, input logic [31:0] addr,
			input logic [31:0] wdata);
		logic [31:0] d;
		int lat;
		access(1'b0, size, addr, wdata, d, lat);
	endtask

	function automatic logic [31:0] set3_addr(input int i);
		return ((32'h10 + 32'(i)) << 10) | (32'd3 << 6);
	endfunction

	initial begin : stimulus
		logic [31:0] d;
		int lat;
		int wr0;
		int rd0;
		int io0;
		void'($urandom(77));
		inRESET = 1'b0;
		remove = 1'b0;
		sysinfo_iosr_valid = 1'b0;
		sysinfo_iosr = '0;
		ldst_req = 1'b0;
		ldst = '0;
		mem_lock = 1'b0;
		mem_valid = 1'b0;
		mem_rdata = '0;
		io_busy = 1'b0;
		io_valid = 1'b0;
		io_pend = 1'b0;
		io_last_addr = '0;
		io_rdata = '0;
		cyc = 0;
		repeat (16) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;

		beat_seen = '0;
		read_expect(32'h0000_1254, 1'b0);
		check_eq("beats covered", 32'(beat_seen), 32'hFF);
		end_test("miss");

		for (int i = 0; i < 16; i++) begin
			read_expect(32'h0000_1240 + 32'(i * 4), 1'b1);
		end
		end_test("hit");

		wr0 = wr_issued;
		write_word(dcache_pkg::SIZE_BYTE, 32'h0000_1241, 32'h0000_00AB);
		write_word(dcache_pkg::SIZE_HALF, 32'h0000_1246, 32'h0000_1234);
		write_word(dcache_pkg::SIZE_WORD, 32'h0000_1248, 32'hDEAD_BEEF);
		check_eq("mem writes", 32'(wr_issued - wr0), 32'd3);
		read_expect(32'h0000_1240, 1'b1);
		read_expect(32'h0000_1244, 1'b1);
		read_expect(32'h0000_1248, 1'b1);
		end_test("write");

		@(negedge iCLOCK);
		sysinfo_iosr_valid = 1'b1;
		sysinfo_iosr = IO_BASE;
		@(negedge iCLOCK);
		sysinfo_iosr_valid = 1'b0;
		rd0 = rd_issued;
		wr0 = wr_issued;
		io0 = io_seen;
		access(1'b1, dcache_pkg::SIZE_WORD, IO_BASE + 32'h120, '0, d, lat);
		check_eq("io read data", d, 32'h120 ^ IO_KEY);
		check_eq("io read addr", io_last_addr, 32'h120);
		check_eq("io read rw", 32'(io_last_rw), 32'd1);
		check_eq("io read order", 32'(io_last_size), 32'(`DCACHE_IO_ORDER));
		write_word(dcache_pkg::SIZE_WORD, IO_BASE + 32'h200, 32'h1111_2222);
		check_eq("io write addr", io_last_addr, 32'h200);
		check_eq("io write rw", 32'(io_last_rw), 32'd0);
		check_eq("io write data", io_last_wdata, 32'h1111_2222);
		check_eq("io write order", 32'(io_last_size), 32'(`DCACHE_IO_ORDER));
		check_eq("io requests", 32'(io_seen - io0), 32'd2);
		check_eq("io mem traffic", 32'((rd_issued - rd0) + (wr_issued - wr0)), 32'd0);
		read_expect(32'h0000_1254, 1'b1);
		end_test("io");

		for (int i = 0; i < 4; i++) begin
			read_expect(set3_addr(i), 1'b0);
		end
		for (int i = 1; i < 4; i++) begin
			read_expect(set3_addr(i), 1'b1);
		end
		read_expect(set3_addr(4), 1'b0);
		read_expect(set3_addr(1), 1'b1);
		read_expect(set3_addr(3), 1'b1);
		read_expect(set3_addr(4), 1'b1);
		read_expect(set3_addr(0), 1'b0);
		// Tag 2 was the oldest when tag 0 came back
		read_expect(set3_addr(4), 1'b1);
		read_expect(set3_addr(2), 1'b0);
		end_test("lru");

		@(negedge iCLOCK);
		remove = 1'b1;
		@(negedge iCLOCK);
		remove = 1'b0;
		read_expect(32'h0000_1254, 1'b0);
		read_expect(set3_addr(4), 1'b0);
		end_test("remove");

		$display("tests %0d checks %0d errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== dcache_chk.sv ====
`timescale 1ns/1ps

module dcache_chk (
	input logic                  iCLOCK,
	input logic                  inRESET,
	input logic                  sysinfo_iosr_valid,
	input logic [31:0]           sysinfo_iosr,
	input dcache_pkg::ldst_req_t ldst,
	input logic                  io_req,
	input dcache_pkg::io_req_t   io,
	input logic                  mem_req,
	input logic                  ldst_valid,
	input logic                  hit_valid,
	input logic                  hit
);

	logic [31:0] base_q;

	// Shadow copy of the IO base
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			base_q <= '0;
		end else if (sysinfo_iosr_valid) begin
			base_q <= sysinfo_iosr;
		end
	end

	quiet_after_reset: assert property (@(posedge iCLOCK)
		$past(!inRESET) |-> !mem_req && !ldst_valid && !io_req)
		else $error("output active during or right after reset");

	no_mem_after_hit: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(hit_valid && hit) |-> !mem_req ##1 !mem_req)
		else $error("memory request after a read hit");

	io_offset: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		io_req |-> io.addr == ldst.addr - base_q)
		else $error("IO address is not the offset from the base");

	valid_pulse: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_valid |=> !ldst_valid)
		else $error("ldst_valid longer than one cycle");

endmodule

bind dcache_top dcache_chk chk0 (
	.iCLOCK             (iCLOCK),
	.inRESET            (inRESET),
	.sysinfo_iosr_valid (sysinfo_iosr_valid),
	.sysinfo_iosr       (sysinfo_iosr),
	.ldst               (ldst),
	.io_req             (io_req),
	.io                 (io),
	.mem_req            (mem_req),
	.ldst_valid         (ldst_valid),
	.hit_valid          (hit_valid),
	.hit                (hit)
);

// ==== dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  remove,
	input  logic                  sysinfo_iosr_valid,
	input  logic [31:0]           sysinfo_iosr,
	input  logic                  ldst_req,
	input  dcache_pkg::ldst_req_t ldst,
	output logic                  ldst_busy,
	output logic                  ldst_valid,
	output logic [31:0]           ldst_rdata,
	output logic                  mem_req,
	output dcache_pkg::mem_req_t  mem,
	input  logic                  mem_lock,
	input  logic                  mem_valid,
	input  logic [63:0]           mem_rdata,
	output logic                  io_req,
	output dcache_pkg::io_req_t   io,
	input  logic                  io_busy,
	input  logic                  io_valid,
	input  logic [31:0]           io_rdata
);

	logic                   cache_sel;
	logic                   cache_valid;
	logic [31:0]            cache_rdata;
	logic                   lookup_en;
	logic                   hit_valid;
	logic                   hit;
	logic [31:0]            hit_data;
	logic                   update_en;
	dcache_pkg::ldst_req_t  update;
	logic                   fill_en;
	dcache_pkg::fill_beat_t fill;
	logic                   miss_valid;
	logic [31:0]            miss_rdata;
	logic                   ctrl_busy;

	assign ldst_busy = ctrl_busy || mem_lock || io_busy;

	// Hit answers and sequencer completions never overlap
	assign cache_valid = miss_valid || (hit_valid && hit);
	assign cache_rdata = miss_valid ? miss_rdata : hit_data;

	// Write-through request doubles as the array update
	assign update = dcache_pkg::ldst_req_t'(mem);

	dcache_io_route u_route (
		.iCLOCK             (iCLOCK),
		.inRESET            (inRESET),
		.sysinfo_iosr_valid (sysinfo_iosr_valid),
		.sysinfo_iosr       (sysinfo_iosr),
		.ldst_req           (ldst_req),
		.ldst               (ldst),
		.io_busy            (io_busy),
		.io_valid           (io_valid),
		.io_rdata           (io_rdata),
		.cache_valid        (cache_valid),
		.cache_rdata        (cache_rdata),
		.cache_sel          (cache_sel),
		.io_req             (io_req),
		.io                 (io),
		.ldst_valid         (ldst_valid),
		.ldst_rdata         (ldst_rdata)
	);

	dcache_ctrl u_ctrl (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.ldst_req   (ldst_req),
		.ldst       (ldst),
		.cache_sel  (cache_sel),
		.hit_valid  (hit_valid),
		.hit        (hit),
		.mem_lock   (mem_lock),
		.mem_valid  (mem_valid),
		.mem_rdata  (mem_rdata),
		.lookup_en  (lookup_en),
		.update_en  (update_en),
		.fill_en    (fill_en),
		.fill       (fill),
		.mem_req    (mem_req),
		.mem        (mem),
		.miss_valid (miss_valid),
		.miss_rdata (miss_rdata),
		.ctrl_busy  (ctrl_busy)
	);

	dcache_array u_array (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.remove      (remove),
		.lookup_en   (lookup_en),
		.lookup_addr (ldst.addr),
		.hit_valid   (hit_valid),
		.hit         (hit),
		.hit_data    (hit_data),
		.update_en   (update_en),
		.update      (update),
		.fill_en     (fill_en),
		.fill        (fill)
	);

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
	input  logic                   iCLOCK,
	input  logic                   inRESET,
	input  logic                   ldst_req,
	input  dcache_pkg::ldst_req_t  ldst,
	input  logic                   cache_sel,
	input  logic                   hit_valid,
	input  logic                   hit,
	input  logic                   mem_lock,
	input  logic                   mem_valid,
	input  logic [63:0]            mem_rdata,
	output logic                   lookup_en,
	output logic                   update_en,
	output logic                   fill_en,
	output dcache_pkg::fill_beat_t fill,
	output logic                   mem_req,
	output dcache_pkg::mem_req_t   mem,
	output logic                   miss_valid,
	output logic [31:0]            miss_rdata,
	output logic                   ctrl_busy
);

	localparam int BEAT_W = $clog2(`DCACHE_LINE_BEATS);
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DCACHE_LINE_BEATS - 1);

	dcache_pkg::ctrl_state_e state_q;
	dcache_pkg::ldst_req_t   req_q;
	logic [BEAT_W-1:0]       req_cnt_q;
	logic [BEAT_W-1:0]       get_cnt_q;
	logic [31:0]             rdata_q;
	logic                    miss;
	logic                    take;
	logic                    refill;
	logic                    issue;

	// Lookup result of a read that missed
	assign miss = hit_valid && !hit;
	assign ctrl_busy = (state_q != dcache_pkg::IDLE) || miss;

	// Same condition the load/store unit sees as accepted
	assign take = ldst_req && cache_sel && !ctrl_busy && !mem_lock;
	assign lookup_en = take && ldst.rw;

	assign refill = (state_q == dcache_pkg::RD_REQ) || (state_q == dcache_pkg::RD_GET);
	assign mem_req = (state_q == dcache_pkg::RD_REQ) || (state_q == dcache_pkg::WR_REQ);
	assign issue = mem_req && !mem_lock;

	// Cached copy is updated together with the write-through issue
	assign update_en = (state_q == dcache_pkg::WR_REQ) && !mem_lock;
	assign fill_en = refill && mem_valid;

	assign miss_valid = (state_q == dcache_pkg::RD_OUT) || (state_q == dcache_pkg::WR_OUT);
	assign miss_rdata = rdata_q;

	always_comb begin
		fill.beat = get_cnt_q;
		fill.set = req_q.addr[9:6];
		fill.tag = req_q.addr[31:10];
		fill.data = mem_rdata;
	end

	// Refill walks the line beat by beat, writes use the full address
	always_comb begin
		mem.rw = req_q.rw;
		mem.size = req_q.size;
		mem.wdata = req_q.wdata;
		if (state_q == dcache_pkg::WR_REQ) begin
			mem.addr = req_q.addr;
		end else begin
			mem.addr = {req_q.addr[31:6], req_cnt_q, 3'b000};
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= dcache_pkg::IDLE;
			req_cnt_q <= '0;
			get_cnt_q <= '0;
		end else begin
			case (state_q)
				dcache_pkg::IDLE: begin
					req_cnt_q <= '0;
					get_cnt_q <= '0;
					if (miss) begin
						state_q <= dcache_pkg::RD_REQ;
					end else if (take && !ldst.rw) begin
						state_q <= dcache_pkg::WR_REQ;
					end
				end
				dcache_pkg::RD_REQ: begin
					// Returned beats are counted below, in parallel with issue
					if (issue) begin
						req_cnt_q <= req_cnt_q + 1'b1;
						if (req_cnt_q == LAST_BEAT) begin
							state_q <= dcache_pkg::RD_GET;
						end
					end
				end
				dcache_pkg::RD_GET: begin
					if (mem_valid && get_cnt_q == LAST_BEAT) begin
						state_q <= dcache_pkg::RD_OUT;
					end
				end
				dcache_pkg::RD_OUT: begin
					state_q <= dcache_pkg::IDLE;
				end
				dcache_pkg::WR_REQ: begin
					if (issue) begin
						state_q <= dcache_pkg::WR_GET;
					end
				end
				dcache_pkg::WR_GET: begin
					// Write acknowledge from memory
					if (mem_valid) begin
						state_q <= dcache_pkg::WR_OUT;
					end
				end
				dcache_pkg::WR_OUT: begin
					state_q <= dcache_pkg::IDLE;
				end
				default: begin
					state_q <= dcache_pkg::IDLE;
				end
			endcase
			if (fill_en) begin
				get_cnt_q <= get_cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (take) begin
			req_q <= ldst;
		end
		// Keep the addressed word as its beat goes by
		if (fill_en && get_cnt_q == req_q.addr[5:3]) begin
			rdata_q <= req_q.addr[2] ? mem_rdata[63:32] : mem_rdata[31:0];
		end
	end

endmodule

// ==== dcache_array.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_array (
	input  logic                   iCLOCK,
	input  logic                   inRESET,
	input  logic                   remove,
	input  logic                   lookup_en,
	input  logic [31:0]            lookup_addr,
	output logic                   hit_valid,
	output logic                   hit,
	output logic [31:0]            hit_data,
	input  logic                   update_en,
	input  dcache_pkg::ldst_req_t  update,
	input  logic                   fill_en,
	input  dcache_pkg::fill_beat_t fill
);

	localparam int WAY_W = $clog2(`DCACHE_WAYS);

	logic [21:0]            tag_mem [`DCACHE_WAYS][`DCACHE_SETS];
	logic [63:0]            data_mem [`DCACHE_WAYS][`DCACHE_SETS][`DCACHE_LINE_BEATS];
	logic [`DCACHE_WAYS-1:0] valid_q [`DCACHE_SETS];
	// Tree pseudo-LRU, three bits for four ways
	logic [2:0]             plru_q [`DCACHE_SETS];

	logic [`DCACHE_WAYS-1:0] lk_match;
	logic [`DCACHE_WAYS-1:0] up_match;
	logic [WAY_W-1:0]        lk_way;
	logic [WAY_W-1:0]        up_way;
	logic [63:0]             lk_line;
	logic [WAY_W-1:0]        victim;
	logic [WAY_W-1:0]        fill_way_q;
	logic [WAY_W-1:0]        fill_way;
	logic [7:0]              byte_en;
	logic [63:0]             wdata_rep;
	logic [63:0]             up_line;
	logic [63:0]             merged;

	function automatic logic [`DCACHE_WAYS-1:0] match_ways(input logic [31:0] addr);
		logic [`DCACHE_WAYS-1:0] m;
		m = '0;
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			m[w] = valid_q[addr[9:6]][w] && (tag_mem[w][addr[9:6]] == addr[31:10]);
		end
		return m;
	endfunction

	function automatic logic [WAY_W-1:0] way_index(input logic [`DCACHE_WAYS-1:0] onehot);
		logic [WAY_W-1:0] idx;
		idx = '0;
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (onehot[w]) begin
				idx = WAY_W'(w);
			end
		end
		return idx;
	endfunction

	// Bit 0 picks the older pair, bits 1 and 2 the older way inside it
	function automatic logic [WAY_W-1:0] plru_victim(input logic [2:0] tree);
		if (!tree[0]) begin
			return {1'b0, tree[1]};
		end
		return {1'b1, tree[2]};
	endfunction

	function automatic logic [2:0] plru_touch(input logic [2:0] tree, input logic [WAY_W-1:0] way);
		logic [2:0] t;
		t = tree;
		t[0] = ~way[1];
		if (way[1]) begin
			t[2] = ~way[0];
		end else begin
			t[1] = ~way[0];
		end
		return t;
	endfunction

	always_comb begin
		lk_match = match_ways(lookup_addr);
		up_match = match_ways(update.addr);
		lk_way = way_index(lk_match);
		up_way = way_index(up_match);
		lk_line = data_mem[lk_way][lookup_addr[9:6]][lookup_addr[5:3]];
		// Empty ways go first, lowest index wins
		victim = plru_victim(plru_q[fill.set]);
		for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
			if (!valid_q[fill.set][w]) begin
				victim = WAY_W'(w);
			end
		end
		fill_way = (fill.beat == '0) ? victim : fill_way_q;
	end

	// Byte merge for a write hit
	always_comb begin
		case (update.size)
			dcache_pkg::SIZE_BYTE: begin
				byte_en = 8'b0000_0001 << update.addr[2:0];
				wdata_rep = {8{update.wdata[7:0]}};
			end
			dcache_pkg::SIZE_HALF: begin
				byte_en = 8'b0000_0011 << {update.addr[2:1], 1'b0};
				wdata_rep = {4{update.wdata[15:0]}};
			end
			default: begin
				byte_en = 8'b0000_1111 << {update.addr[2], 2'b00};
				wdata_rep = {2{update.wdata}};
			end
		endcase
		up_line = data_mem[up_way][update.addr[9:6]][update.addr[5:3]];
		for (int b = 0; b < 8; b++) begin
			merged[b*8 +: 8] = byte_en[b] ? wdata_rep[b*8 +: 8] : up_line[b*8 +: 8];
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hit_valid <= 1'b0;
			hit <= 1'b0;
			fill_way_q <= '0;
			for (int s = 0; s < `DCACHE_SETS; s++) begin
				valid_q[s] <= '0;
				plru_q[s] <= '0;
			end
		end else begin
			hit_valid <= lookup_en;
			hit <= lookup_en && (|lk_match);
			if (fill_en && fill.beat == '0) begin
				fill_way_q <= victim;
				plru_q[fill.set] <= plru_touch(plru_q[fill.set], victim);
			end else if (lookup_en && (|lk_match)) begin
				plru_q[lookup_addr[9:6]] <= plru_touch(plru_q[lookup_addr[9:6]], lk_way);
			end
			// Line becomes valid once its last beat is in
			if (remove) begin
				for (int s = 0; s < `DCACHE_SETS; s++) begin
					valid_q[s] <= '0;
				end
			end else if (fill_en && fill.beat == 3'(`DCACHE_LINE_BEATS - 1)) begin
				valid_q[fill.set][fill_way] <= 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (lookup_en) begin
			hit_data <= lookup_addr[2] ? lk_line[63:32] : lk_line[31:0];
		end
		if (fill_en) begin
			data_mem[fill_way][fill.set][fill.beat] <= fill.data;
			if (fill.beat == '0) begin
				tag_mem[fill_way][fill.set] <= fill.tag;
			end
		end else if (update_en && (|up_match)) begin
			data_mem[up_way][update.addr[9:6]][update.addr[5:3]] <= merged;
		end
	end

endmodule

// ==== dcache_io_route.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_io_route (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  sysinfo_iosr_valid,
	input  logic [31:0]           sysinfo_iosr,
	input  logic                  ldst_req,
	input  dcache_pkg::ldst_req_t ldst,
	input  logic                  io_busy,
	input  logic                  io_valid,
	input  logic [31:0]           io_rdata,
	input  logic                  cache_valid,
	input  logic [31:0]           cache_rdata,
	output logic                  cache_sel,
	output logic                  io_req,
	output dcache_pkg::io_req_t   io,
	output logic                  ldst_valid,
	output logic [31:0]           ldst_rdata
);

	logic        io_base_valid;
	logic [31:0] io_base;
	logic        io_region;
	logic        io_sel;

	// IO base, written once by the system
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			io_base_valid <= 1'b0;
			io_base <= '0;
		end else if (sysinfo_iosr_valid) begin
			io_base_valid <= 1'b1;
			io_base <= sysinfo_iosr;
		end
	end

	// Without a base everything is memory
	assign io_region = io_base_valid && (ldst.addr >= io_base);
	assign io_sel = ldst_req && io_region;
	assign cache_sel = ldst_req && !io_region && !io_busy;
	assign io_req = io_sel;

	always_comb begin
		io.rw = ldst.rw;
		io.size = dcache_pkg::access_size_e'(`DCACHE_IO_ORDER);
		io.addr = ldst.addr - io_base;
		io.wdata = ldst.wdata;
	end

	// IO answer wins over the cache
	assign ldst_valid = io_valid || cache_valid;
	assign ldst_rdata = io_valid ? io_rdata : cache_rdata;

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

	// Cached address split
	//   tag         addr[31:10]
	//   set         addr[9:6]
	//   beat        addr[5:3]
	//   word select addr[2]
	//   byte lane   addr[1:0]
	// Reads return the whole aligned 32-bit word
	// Write data sits in the low bits and lands at the byte lane of the address

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_e;

	// Refill and write-through sequencer
	typedef enum logic [2:0] {
		IDLE   = 3'd0,
		RD_REQ = 3'd1,
		RD_GET = 3'd2,
		RD_OUT = 3'd3,
		WR_REQ = 3'd4,
		WR_GET = 3'd5,
		WR_OUT = 3'd6
	} ctrl_state_e;

	// rw is 1 for a read and 0 for a write
	typedef struct packed {
		logic         rw;
		access_size_e size;
		logic [31:0]  addr;
		logic [31:0]  wdata;
	} ldst_req_t;

	typedef struct packed {
		logic         rw;
		access_size_e size;
		logic [31:0]  addr;
		logic [31:0]  wdata;
	} mem_req_t;

	typedef struct packed {
		logic         rw;
		access_size_e size;
		logic [31:0]  addr;
		logic [31:0]  wdata;
	} io_req_t;

	// One refill beat headed for the array
	typedef struct packed {
		logic [2:0]  beat;
		logic [3:0]  set;
		logic [21:0] tag;
		logic [63:0] data;
	} fill_beat_t;

endpackage

// ==== dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
// Four ways of sixteen sets, each line is 64 bytes
`define DCACHE_WAYS 4
`define DCACHE_SETS 16

// Refill beats of 64 bits per line
`define DCACHE_LINE_BEATS 8

// Access order driven on every IO request
// Encoded like the word access size
`define DCACHE_IO_ORDER 2

`endif
